/* source/mem_pkg.sv */
`default_nettype none

package mem_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] word_t;

  // low 1, 2 or 4 byte lanes
  typedef enum logic [1:0] {
    WS_BYTE,
    WS_HALF,
    WS_WORD
  } write_size_e;

  typedef enum logic {
    MEM_IDLE,
    MEM_BUSY
  } mem_state_e;

endpackage

`default_nettype wire

/* source/cache_pkg.sv */
`default_nettype none

package cache_pkg;

  import mem_pkg::*;

  typedef logic [7:0] instr_tag_t;

  typedef enum logic [1:0] {
    INVALID,
    VALID,
    WAITING,
    MODIFIED
  } line_state_e;

  typedef enum logic [1:0] {
    FILL_IDLE,
    FILL_REQUEST,
    FILL_WAIT,
    FILL_WRITE
  } fill_state_e;

  typedef struct packed {
    word_t       data;
    addr_t       address;
    instr_tag_t  instr;
    line_state_e state;
    write_size_e ws;
  } line_record_t;

endpackage

`default_nettype wire

/* source/cache_ifs.sv */
`timescale 1ns/1ps
`default_nettype none

interface mem_bus_if import mem_pkg::*; ();

  logic        read;
  logic        write;
  addr_t       address;
  word_t       wdata;
  write_size_e ws;
  word_t       rdata;
  logic        done;

  modport cache (
    output read, write, address, wdata, ws,
    input  rdata, done
  );

  modport memory (
    input  read, write, address, wdata, ws,
    output rdata, done
  );

endinterface

interface wb_queue_if import cache_pkg::*; ();

  logic         push;
  line_record_t push_record;
  logic         head_valid;
  line_record_t head_record;
  logic         pop;

  modport queue (
    input  push, push_record, pop,
    output head_valid, head_record
  );

  modport cache (
    input  head_valid, head_record,
    output pop
  );

  modport victim (
    output push, push_record
  );

endinterface

`default_nettype wire

/* source/line_store.sv */
`timescale 1ns/1ps
`default_nettype none

module line_store import mem_pkg::*, cache_pkg::*; #(
  parameter int cache_lines = 8
) (
  input  logic        global_signals,
  input  logic        reset,
  input  addr_t       lookup_address,
  output logic        lookup_hit,
  output word_t       lookup_data,
  input  logic        fill,
  input  addr_t       fill_address,
  input  word_t       fill_data,
  input  logic        store_write,
  input  addr_t       store_address,
  input  word_t       store_data,
  input  instr_tag_t  store_tag,
  input  write_size_e store_ws,
  input  logic        commit_valid_a,
  input  logic        commit_valid_b,
  input  instr_tag_t  commit_tag_a,
  input  instr_tag_t  commit_tag_b,
  input  logic        queue_full,
  output logic        store_ready,
  wb_queue_if.victim  victim
);

  localparam int idx_w = (cache_lines > 1) ? $clog2(cache_lines) : 1;

  line_record_t lines [cache_lines];

  logic             have_same;
  logic             have_invalid;
  logic             have_valid;
  logic             have_modified;
  logic [idx_w-1:0] same_idx;
  logic [idx_w-1:0] invalid_idx;
  logic [idx_w-1:0] valid_idx;
  logic [idx_w-1:0] modified_idx;
  logic [idx_w-1:0] victim_idx;
  logic [idx_w-1:0] store_idx;
  logic             store_push;
  logic             fill_push;
  logic             store_take;
  logic             fill_take;

  // all lines searched at once, lowest index wins
  always_comb begin
    lookup_hit    = 1'b0;
    lookup_data   = '0;
    have_same     = 1'b0;
    have_invalid  = 1'b0;
    have_valid    = 1'b0;
    have_modified = 1'b0;
    same_idx      = '0;
    invalid_idx   = '0;
    valid_idx     = '0;
    modified_idx  = '0;
    for (int i = cache_lines - 1; i >= 0; i--) begin
      if (lines[i].state == VALID || lines[i].state == MODIFIED) begin
        if (lines[i].address == lookup_address) begin
          lookup_hit  = 1'b1;
          lookup_data = lines[i].data;
        end
        if (lines[i].address == store_address) begin
          have_same = 1'b1;
          same_idx  = idx_w'(i);
        end
      end
      if (lines[i].state == INVALID) begin
        have_invalid = 1'b1;
        invalid_idx  = idx_w'(i);
      end
      if (lines[i].state == VALID) begin
        have_valid = 1'b1;
        valid_idx  = idx_w'(i);
      end
      if (lines[i].state == MODIFIED) begin
        have_modified = 1'b1;
        modified_idx  = idx_w'(i);
      end
    end
  end

  // victim order: invalid, valid, modified
  always_comb begin
    if (have_invalid) begin
      victim_idx = invalid_idx;
    end else if (have_valid) begin
      victim_idx = valid_idx;
    end else begin
      victim_idx = modified_idx;
    end
  end

  assign store_idx   = have_same ? same_idx : victim_idx;
  assign store_push  = lines[store_idx].state == MODIFIED;
  assign fill_push   = lines[victim_idx].state == MODIFIED;
  assign store_ready = (have_same || have_invalid || have_valid || have_modified) &&
                       !(store_push && queue_full);
  assign store_take  = store_write && store_ready;
  assign fill_take   = fill && (have_invalid || have_valid || have_modified) &&
                       !(fill_push && queue_full);

  assign victim.push        = (store_take && store_push) || (fill_take && fill_push);
  assign victim.push_record = (store_take && store_push) ? lines[store_idx] : lines[victim_idx];

  always_ff @(posedge global_signals) begin
    if (reset) begin
      for (int i = 0; i < cache_lines; i++) begin
        lines[i].state <= INVALID;
      end
    end else begin
      for (int i = 0; i < cache_lines; i++) begin
        if (lines[i].state == WAITING &&
            ((commit_valid_a && lines[i].instr == commit_tag_a) ||
             (commit_valid_b && lines[i].instr == commit_tag_b))) begin
          lines[i].state <= MODIFIED;
        end
      end
      if (fill_take) begin
        lines[victim_idx] <= '{data: fill_data, address: fill_address, instr: '0,
                               state: VALID, ws: WS_WORD};
      end
      if (store_take) begin
        lines[store_idx] <= '{data: store_data, address: store_address, instr: store_tag,
                              state: WAITING, ws: store_ws};
      end
    end
  end

endmodule

`default_nettype wire

/* source/write_back_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module write_back_queue import cache_pkg::*; #(
  parameter int cache_lines = 8
) (
  input  logic      global_signals,
  input  logic      reset,
  wb_queue_if.queue queue,
  output logic      full
);

  localparam int ptr_w = (cache_lines > 1) ? $clog2(cache_lines) : 1;

  line_record_t     slots [cache_lines];
  logic [ptr_w-1:0] head;
  logic [ptr_w-1:0] tail;
  logic [ptr_w:0]   count;
  logic             do_push;
  logic             do_pop;

  function automatic logic [ptr_w-1:0] next_ptr(input logic [ptr_w-1:0] ptr);
    return (ptr == ptr_w'(cache_lines - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full              = count == (ptr_w + 1)'(cache_lines);
  assign queue.head_valid  = count != '0;
  assign queue.head_record = slots[head];
  assign do_pop            = queue.pop && queue.head_valid;
  // a pop frees the slot a full queue needs
  assign do_push           = queue.push && (!full || do_pop);

  always_ff @(posedge global_signals) begin
    if (reset) begin
      head  <= '0;
      tail  <= '0;
      count <= '0;
    end else begin
      if (do_push) begin
        tail <= next_ptr(tail);
      end
      if (do_pop) begin
        head <= next_ptr(head);
      end
      if (do_push && !do_pop) begin
        count <= count + 1'b1;
      end else if (do_pop && !do_push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge global_signals) begin
    if (do_push) begin
      slots[tail] <= queue.push_record;
    end
  end

endmodule

`default_nettype wire

/* source/data_cache.sv */
`timescale 1ns/1ps
`default_nettype none

module data_cache import mem_pkg::*, cache_pkg::*; #(
  parameter int cache_lines = 8
) (
  input  logic        global_signals,
  input  logic        reset,
  input  logic        load_read,
  input  addr_t       load_address,
  output logic        load_hit,
  output word_t       load_data,
  input  logic        store_write,
  input  addr_t       store_address,
  input  word_t       store_data,
  input  instr_tag_t  store_tag,
  input  write_size_e store_ws,
  input  logic        commit_valid_a,
  input  logic        commit_valid_b,
  input  instr_tag_t  commit_tag_a,
  input  instr_tag_t  commit_tag_b,
  output logic        store_ready,
  mem_bus_if.cache    mem
);

  wb_queue_if wbq ();

  fill_state_e fill_state;
  logic        lookup_hit;
  word_t       lookup_data;
  logic        miss;
  logic        fill;
  logic        queue_full;
  logic        lines_ready;

  assign miss    = load_read && !lookup_hit;
  assign fill    = (fill_state == FILL_WAIT) && mem.done;
  assign wbq.pop = (fill_state == FILL_WRITE) && mem.done;
  // keeps the fill victim away from a racing store
  assign store_ready = lines_ready && (fill_state != FILL_WAIT);

  line_store #(.cache_lines(cache_lines)) u_line_store (
    .global_signals(global_signals), .reset(reset),
    .lookup_address(load_address), .lookup_hit(lookup_hit), .lookup_data(lookup_data),
    .fill(fill), .fill_address(mem.address), .fill_data(mem.rdata),
    .store_write(store_write), .store_address(store_address), .store_data(store_data),
    .store_tag(store_tag), .store_ws(store_ws),
    .commit_valid_a(commit_valid_a), .commit_valid_b(commit_valid_b),
    .commit_tag_a(commit_tag_a), .commit_tag_b(commit_tag_b),
    .queue_full(queue_full), .store_ready(lines_ready), .victim(wbq.victim)
  );

  write_back_queue #(.cache_lines(cache_lines)) u_write_back_queue (
    .global_signals(global_signals), .reset(reset), .queue(wbq.queue), .full(queue_full)
  );

  always_ff @(posedge global_signals) begin
    if (reset) begin
      load_hit <= 1'b0;
    end else begin
      load_hit <= load_read && lookup_hit;
    end
  end

  always_ff @(posedge global_signals) begin
    if (load_read && lookup_hit) begin
      load_data <= lookup_data;
    end
  end

  // write-back first, reads only with an empty queue
  always_ff @(posedge global_signals) begin
    if (reset) begin
      fill_state <= FILL_IDLE;
      mem.read   <= 1'b0;
      mem.write  <= 1'b0;
    end else begin
      case (fill_state)
        FILL_IDLE, FILL_REQUEST: begin
          if (wbq.head_valid) begin
            mem.write  <= 1'b1;
            fill_state <= FILL_WRITE;
          end else if (fill_state == FILL_REQUEST && miss) begin
            mem.read   <= 1'b1;
            fill_state <= FILL_WAIT;
          end else begin
            fill_state <= miss ? FILL_REQUEST : FILL_IDLE;
          end
        end
        FILL_WAIT: begin
          if (mem.done) begin
            mem.read   <= 1'b0;
            fill_state <= FILL_IDLE;
          end
        end
        FILL_WRITE: begin
          if (mem.done) begin
            mem.write  <= 1'b0;
            fill_state <= FILL_IDLE;
          end
        end
        default: fill_state <= FILL_IDLE;
      endcase
    end
  end

  // request payload only moves while no request is up
  always_ff @(posedge global_signals) begin
    if (fill_state == FILL_IDLE || fill_state == FILL_REQUEST) begin
      if (wbq.head_valid) begin
        mem.address <= wbq.head_record.address;
        mem.wdata   <= wbq.head_record.data;
        mem.ws      <= wbq.head_record.ws;
      end else begin
        mem.address <= load_address;
      end
    end
  end

endmodule

`default_nettype wire

/* source/data_memory.sv */
`timescale 1ns/1ps
`default_nettype none

module data_memory import mem_pkg::*; #(
  parameter int mem_latency = 3,
  parameter int mem_words   = 256
) (
  input  logic      global_signals,
  input  logic      reset,
  mem_bus_if.memory mem
);

  localparam int idx_w = (mem_words > 1) ? $clog2(mem_words) : 1;
  localparam int cnt_w = $clog2(mem_latency + 1) + 1;

  word_t            words [mem_words];
  mem_state_e       state;
  logic [cnt_w-1:0] count;
  logic [idx_w-1:0] index;
  logic             finish;

  function automatic word_t merge_lanes(input word_t old_word, input word_t new_word,
                                        input write_size_e ws);
    case (ws)
      WS_BYTE: return {old_word[31:8], new_word[7:0]};
      WS_HALF: return {old_word[31:16], new_word[15:0]};
      default: return new_word;
    endcase
  endfunction

  // upper address bits ignored
  assign index  = mem.address[idx_w-1:0];
  assign finish = (state == MEM_BUSY) && (count == cnt_w'(mem_latency));

  initial begin
    for (int i = 0; i < mem_words; i++) begin
      words[i] = '0;
    end
  end

  always_ff @(posedge global_signals) begin
    if (reset) begin
      state    <= MEM_IDLE;
      count    <= '0;
      mem.done <= 1'b0;
    end else begin
      mem.done <= finish;
      if (finish) begin
        state <= MEM_IDLE;
      end else if (state == MEM_BUSY) begin
        count <= count + 1'b1;
      end else if ((mem.read || mem.write) && !mem.done) begin
        // the held request is not taken again in its done cycle
        state <= MEM_BUSY;
        count <= cnt_w'(1);
      end
    end
  end

  always_ff @(posedge global_signals) begin
    if (finish) begin
      if (mem.write) begin
        words[index] <= merge_lanes(words[index], mem.wdata, mem.ws);
      end else begin
        mem.rdata <= words[index];
      end
    end
  end

endmodule

`default_nettype wire

/* source/data_subsystem.sv */
`timescale 1ns/1ps
`default_nettype none

module data_subsystem import mem_pkg::*, cache_pkg::*; #(
  parameter int cache_lines = 8,
  parameter int mem_latency = 3,
  parameter int mem_words   = 256
) (
  input  logic        global_signals,
  input  logic        reset,
  input  logic        load_read,
  input  addr_t       load_address,
  output logic        load_hit,
  output word_t       load_data,
  input  logic        store_write,
  input  addr_t       store_address,
  input  word_t       store_data,
  input  instr_tag_t  store_tag,
  input  write_size_e store_ws,
  input  logic        commit_valid_a,
  input  instr_tag_t  commit_tag_a,
  input  logic        commit_valid_b,
  input  instr_tag_t  commit_tag_b,
  output logic        store_ready
);

  mem_bus_if bus ();

  data_cache #(.cache_lines(cache_lines)) u_data_cache (
    .global_signals(global_signals), .reset(reset),
    .load_read(load_read), .load_address(load_address),
    .load_hit(load_hit), .load_data(load_data),
    .store_write(store_write), .store_address(store_address), .store_data(store_data),
    .store_tag(store_tag), .store_ws(store_ws),
    .commit_valid_a(commit_valid_a), .commit_valid_b(commit_valid_b),
    .commit_tag_a(commit_tag_a), .commit_tag_b(commit_tag_b),
    .store_ready(store_ready), .mem(bus.cache)
  );

  data_memory #(
    .mem_latency(mem_latency),
    .mem_words(mem_words)
  ) u_data_memory (
    .global_signals(global_signals),
    .reset(reset),
    .mem(bus.memory)
  );

endmodule

`default_nettype wire

/* sim/data_subsystem_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module data_subsystem_chk import mem_pkg::*; (
  input logic  global_signals,
  input logic  reset,
  input logic  read,
  input logic  write,
  input logic  done,
  input addr_t address
);

  a_one_request: assert property (
    @(posedge global_signals) disable iff (reset) !(read && write)
  ) else $error("memory read and write requested in the same cycle");

  a_done_pulse: assert property (
    @(posedge global_signals) disable iff (reset) done |=> !done
  ) else $error("memory done held longer than one cycle");

  // address held until the memory answers
  a_address_stable: assert property (
    @(posedge global_signals) disable iff (reset) (read || write) && !done |=> $stable(address)
  ) else $error("memory address changed while a request was held");

endmodule

bind data_memory data_subsystem_chk u_chk (
  .global_signals(global_signals),
  .reset(reset),
  .read(mem.read),
  .write(mem.write),
  .done(mem.done),
  .address(mem.address)
);

`default_nettype wire

/* sim/data_subsystem_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module data_subsystem_tb import mem_pkg::*, cache_pkg::*; ();

  localparam int cache_lines = 4;
  localparam int mem_latency = 3;
  localparam int mem_words   = 256;
  // 100 random ops of up to 30 cycles plus the directed tests
  localparam int cycle_limit = 4000;

  logic        global_signals;
  logic        reset;
  logic        load_read;
  addr_t       load_address;
  logic        load_hit;
  word_t       load_data;
  logic        store_write;
  addr_t       store_address;
  word_t       store_data;
  instr_tag_t  store_tag;
  write_size_e store_ws;
  logic        commit_valid_a;
  instr_tag_t  commit_tag_a;
  logic        commit_valid_b;
  instr_tag_t  commit_tag_b;
  logic        store_ready;

  // model of memory and lines
  word_t       model_mem [mem_words];
  line_state_e m_state [cache_lines];
  addr_t       m_addr [cache_lines];
  word_t       m_data [cache_lines];
  write_size_e m_ws [cache_lines];
  instr_tag_t  m_tag [cache_lines];

  string       test_name;
  word_t       exp_data;
  instr_tag_t  next_tag;
  int          errors;
  int          checks;
  int          cycles;

  data_subsystem #(
    .cache_lines(cache_lines),
    .mem_latency(mem_latency),
    .mem_words(mem_words)
  ) dut (
    .global_signals(global_signals), .reset(reset),
    .load_read(load_read), .load_address(load_address),
    .load_hit(load_hit), .load_data(load_data),
    .store_write(store_write), .store_address(store_address), .store_data(store_data),
    .store_tag(store_tag), .store_ws(store_ws),
    .commit_valid_a(commit_valid_a), .commit_tag_a(commit_tag_a),
    .commit_valid_b(commit_valid_b), .commit_tag_b(commit_tag_b),
    .store_ready(store_ready)
  );

  initial begin
    global_signals = 1'b0;
    forever #50 global_signals = ~global_signals;
  end

  function automatic word_t merged_word(input word_t old_word, input word_t new_word,
                                        input write_size_e ws);
    word_t mask;
    case (ws)
      WS_BYTE: mask = 32'h0000_00ff;
      WS_HALF: mask = 32'h0000_ffff;
      default: mask = 32'hffff_ffff;
    endcase
    return (old_word & ~mask) | (new_word & mask);
  endfunction

  function automatic int first_line_in(input line_state_e s);
    int found;
    found = -1;
    for (int i = 0; i < cache_lines; i++) begin
      if (found < 0 && m_state[i] == s) begin
        found = i;
      end
    end
    return found;
  endfunction

  function automatic int victim_line();
    int v;
    v = first_line_in(INVALID);
    if (v < 0) begin
      v = first_line_in(VALID);
    end
    if (v < 0) begin
      v = first_line_in(MODIFIED);
    end
    return v;
  endfunction

  function automatic int resident_line(input addr_t addr);
    int found;
    found = -1;
    for (int i = 0; i < cache_lines; i++) begin
      if (found < 0 && (m_state[i] == VALID || m_state[i] == MODIFIED) && m_addr[i] == addr) begin
        found = i;
      end
    end
    return found;
  endfunction

  // written back lines reach memory before any later fill reads it
  function automatic void evict_line(input int i);
    if (m_state[i] == MODIFIED) begin
      model_mem[m_addr[i][7:0]] = merged_word(model_mem[m_addr[i][7:0]], m_data[i], m_ws[i]);
    end
  endfunction

  function automatic void record_store(input addr_t addr, input word_t data,
                                       input instr_tag_t tag, input write_size_e ws);
    int i;
    i = resident_line(addr);
    if (i < 0) begin
      i = victim_line();
    end
    evict_line(i);
    m_state[i] = WAITING;
    m_addr[i]  = addr;
    m_data[i]  = data;
    m_ws[i]    = ws;
    m_tag[i]   = tag;
  endfunction

  function automatic void promote_committed(input instr_tag_t tag);
    for (int i = 0; i < cache_lines; i++) begin
      if (m_state[i] == WAITING && m_tag[i] == tag) begin
        m_state[i] = MODIFIED;
      end
    end
  endfunction

  // load result with the model filled on a miss
  function automatic word_t expected_load(input addr_t addr);
    int i;
    i = resident_line(addr);
    if (i < 0) begin
      i = victim_line();
      evict_line(i);
      m_state[i] = VALID;
      m_addr[i]  = addr;
      m_data[i]  = model_mem[addr[7:0]];
      m_ws[i]    = WS_WORD;
    end
    return m_data[i];
  endfunction

  task automatic load_word(input string name, input addr_t addr);
    test_name = name;
    exp_data  = expected_load(addr);
    @(posedge global_signals);
    load_read    <= 1'b1;
    load_address <= addr;
    while (!load_hit) begin
      @(negedge global_signals);
    end
    @(posedge global_signals);
    load_read <= 1'b0;
    while (load_hit) begin
      @(negedge global_signals);
    end
  endtask

  task automatic issue_store(input addr_t addr, input word_t data, input write_size_e ws,
                             output instr_tag_t tag);
    tag      = next_tag;
    next_tag = next_tag + 8'd1;
    @(posedge global_signals);
    store_address <= addr;
    store_data    <= data;
    store_tag     <= tag;
    store_ws      <= ws;
    @(negedge global_signals);
    while (!store_ready) begin
      @(negedge global_signals);
    end
    @(posedge global_signals);
    store_write <= 1'b1;
    @(posedge global_signals);
    store_write <= 1'b0;
    record_store(addr, data, tag, ws);
  endtask

  task automatic broadcast_commit(input instr_tag_t tag, input logic on_b);
    @(posedge global_signals);
    if (on_b) begin
      commit_valid_b <= 1'b1;
      commit_tag_b   <= tag;
    end else begin
      commit_valid_a <= 1'b1;
      commit_tag_a   <= tag;
    end
    @(posedge global_signals);
    commit_valid_a <= 1'b0;
    commit_valid_b <= 1'b0;
    promote_committed(tag);
  endtask

  task automatic end_run();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  always @(negedge global_signals) begin
    if (!reset && load_hit) begin
      checks = checks + 1;
      assert (load_data === exp_data) else begin
        errors = errors + 1;
        $display("ERROR %s: expected %h, actual %h", test_name, exp_data, load_data);
      end
    end
  end

  initial begin
    cycles = 0;
    while (cycles < cycle_limit) begin
      @(posedge global_signals);
      cycles = cycles + 1;
    end
    errors = errors + 1;
    $display("timeout: the run did not finish within %0d clock cycles", cycle_limit);
    end_run();
  end

  initial begin
    instr_tag_t held [4];
    instr_tag_t tag;
    instr_tag_t pending_tag;
    logic       pending;
    addr_t      pending_addr;
    addr_t      addr;
    int         op;

    void'($urandom(77178));
    reset          = 1'b1;
    load_read      = 1'b0;
    load_address   = '0;
    store_write    = 1'b0;
    store_address  = '0;
    store_data     = '0;
    store_tag      = '0;
    store_ws       = WS_WORD;
    commit_valid_a = 1'b0;
    commit_tag_a   = '0;
    commit_valid_b = 1'b0;
    commit_tag_b   = '0;
    next_tag       = '0;
    errors         = 0;
    checks         = 0;
    test_name      = "reset";
    exp_data       = '0;
    for (int i = 0; i < mem_words; i++) begin
      model_mem[i] = '0;
    end
    for (int i = 0; i < cache_lines; i++) begin
      m_state[i] = INVALID;
    end

    repeat (5) @(posedge global_signals);
    reset <= 1'b0;

    load_word("untouched_miss", 32'h20);
    load_word("untouched_repeat", 32'h20);

    issue_store(32'h30, 32'hcafe_0130, WS_WORD, tag);
    broadcast_commit(tag, 1'b0);
    load_word("commit_bus_a", 32'h30);
    issue_store(32'h31, 32'h5a5a_0131, WS_HALF, tag);
    broadcast_commit(tag, 1'b1);
    load_word("commit_bus_b", 32'h31);

    // one line held WAITING while the rest keep serving loads
    issue_store(32'h50, $urandom, WS_WORD, held[0]);
    load_word("serviceable_hit", 32'h30);
    load_word("serviceable_hit", 32'h20);
    load_word("serviceable_fill", 32'h21);
    for (int k = 1; k < 4; k++) begin
      issue_store(32'h50 + k, $urandom, WS_WORD, held[k]);
    end
    @(negedge global_signals);
    assert (!store_ready) else begin
      errors = errors + 1;
      $display("ERROR all_waiting_back_pressure: expected store_ready %b, actual %b",
               1'b0, store_ready);
    end
    for (int k = 0; k < 4; k++) begin
      broadcast_commit(held[k], 1'(k % 2));
    end
    load_word("late_commit", 32'h50);

    // six addresses over four lines
    for (int k = 0; k < 6; k++) begin
      issue_store(32'h60 + k, $urandom, WS_WORD, tag);
      broadcast_commit(tag, 1'(k % 2));
    end
    for (int k = 0; k < 6; k++) begin
      issue_store(32'h60 + k, $urandom, (k % 2 == 0) ? WS_BYTE : WS_HALF, tag);
      broadcast_commit(tag, 1'b0);
    end
    for (int k = 0; k < 6; k++) begin
      load_word("eviction_reload", 32'h60 + k);
    end

    // at most one uncommitted store and never a load of it
    pending      = 1'b0;
    pending_tag  = '0;
    pending_addr = '0;
    for (int n = 0; n < 100; n++) begin
      op   = int'($urandom % 3);
      addr = 32'h70 + ($urandom % 8);
      if (op == 0 && !pending) begin
        issue_store(addr, $urandom, write_size_e'(2'($urandom % 3)), pending_tag);
        pending      = 1'b1;
        pending_addr = addr;
      end else if (op != 2 && pending) begin
        broadcast_commit(pending_tag, 1'($urandom % 2));
        pending = 1'b0;
      end else begin
        if (pending && addr == pending_addr) begin
          addr = addr ^ 32'h8;
        end
        load_word("random_mix", addr);
      end
    end

    repeat (2) @(posedge global_signals);
    end_run();
  end

endmodule

`default_nettype wire

/* compile.f */
source/mem_pkg.sv
source/cache_pkg.sv
source/cache_ifs.sv
source/line_store.sv
source/write_back_queue.sv
source/data_cache.sv
source/data_memory.sv
source/data_subsystem.sv
sim/data_subsystem_chk.sv
sim/data_subsystem_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= data_subsystem_tb
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@grep -q "Simulation completed successfully" $(LOG) || (echo "test: FAILED"; exit 1)
	@echo "test: PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)
